// ==== Makefile ====
TOP = tb_div_cluster

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module div_cluster

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== sources.f ====
src/ooo_pkg.sv
src/phys_regfile.sv
src/div_rs.sv
src/div_unit.sv
src/alu_unit.sv
src/cdb_arbiter.sv
src/div_cluster.sv
test/tb_clock.sv
test/tb_div_cluster.sv

// ==== src/alu_unit.sv ====
`default_nettype none

module alu_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush,
  input  logic             alu_start,
  input  ooo_pkg::tag_t    alu_rd,
  input  ooo_pkg::alu_op_t alu_op,
  input  ooo_pkg::tag_t    alu_src1,
  input  ooo_pkg::tag_t    alu_src2,
  output ooo_pkg::tag_t    alu_tag_a,
  output ooo_pkg::tag_t    alu_tag_b,
  input  ooo_pkg::data_t   alu_val_a,
  input  ooo_pkg::data_t   alu_val_b,
  output logic             alu_busy,
  output logic             alu_req,
  output ooo_pkg::tag_t    alu_res_tag,
  output ooo_pkg::data_t   alu_res_value,
  input  logic             alu_grant
);

  logic accept;

  assign accept    = alu_start && !alu_req;
  assign alu_tag_a = alu_src1;
  assign alu_tag_b = alu_src2;
  assign alu_busy  = alu_req;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      alu_req <= 1'b0;
    end else if (accept) begin
      alu_req <= 1'b1;
    end else if (alu_grant) begin
      alu_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      alu_res_tag   <= alu_rd;
      alu_res_value <= alu_op ? (alu_val_a - alu_val_b) : (alu_val_a + alu_val_b); // wraps.
    end
  end

endmodule

`default_nettype wire

// ==== src/cdb_arbiter.sv ====
`default_nettype none

module cdb_arbiter (
  input  logic           alu_req,
  input  ooo_pkg::tag_t  alu_res_tag,
  input  ooo_pkg::data_t alu_res_value,
  input  logic           div_req,
  input  ooo_pkg::tag_t  div_res_tag,
  input  ooo_pkg::data_t div_res_value,
  output logic           alu_grant,
  output logic           div_grant,
  output logic           cdb_valid,
  output ooo_pkg::tag_t  cdb_tag,
  output ooo_pkg::data_t cdb_value
);

  // the divider waits whenever the ALU has a result.
  assign alu_grant = alu_req;
  assign div_grant = div_req && !alu_req;

  assign cdb_valid = alu_req || div_req;
  assign cdb_tag   = alu_req ? alu_res_tag : div_res_tag;
  assign cdb_value = alu_req ? alu_res_value : div_res_value;

endmodule

`default_nettype wire

// ==== src/div_cluster.sv ====
`default_nettype none

module div_cluster #(
  parameter int RS_SIZE = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush,
  input  logic             load_en,
  input  ooo_pkg::tag_t    load_tag,
  input  ooo_pkg::data_t   load_value,
  input  logic             div_start,
  input  ooo_pkg::tag_t    div_rd,
  input  ooo_pkg::div_op_t div_op,
  input  ooo_pkg::tag_t    div_src1,
  input  ooo_pkg::tag_t    div_src2,
  input  logic [1:0]       div_rdy,
  input  logic             alu_start,
  input  ooo_pkg::tag_t    alu_rd,
  input  ooo_pkg::alu_op_t alu_op,
  input  ooo_pkg::tag_t    alu_src1,
  input  ooo_pkg::tag_t    alu_src2,
  output logic             rs_full,
  output logic             alu_busy,
  output logic             div_busy,
  output logic             cdb_valid,
  output ooo_pkg::tag_t    cdb_tag,
  output ooo_pkg::data_t   cdb_value
);

  logic             issue;
  ooo_pkg::tag_t    issue_rd;
  ooo_pkg::div_op_t issue_op;
  ooo_pkg::tag_t    issue_src1;
  ooo_pkg::tag_t    issue_src2;
  ooo_pkg::data_t   rd_val_a;
  ooo_pkg::data_t   rd_val_b;
  ooo_pkg::tag_t    alu_tag_a;
  ooo_pkg::tag_t    alu_tag_b;
  ooo_pkg::data_t   alu_val_a;
  ooo_pkg::data_t   alu_val_b;
  logic             alu_req;
  ooo_pkg::tag_t    alu_res_tag;
  ooo_pkg::data_t   alu_res_value;
  logic             alu_grant;
  logic             div_req;
  ooo_pkg::tag_t    div_res_tag;
  ooo_pkg::data_t   div_res_value;
  logic             div_grant;

  phys_regfile i_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_en    (load_en),
    .load_tag   (load_tag),
    .load_value (load_value),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .cdb_value  (cdb_value),
    .rd_tag_a   (issue_src1), // divider operands are read in the issue cycle.
    .rd_tag_b   (issue_src2),
    .rd_val_a   (rd_val_a),
    .rd_val_b   (rd_val_b),
    .alu_tag_a  (alu_tag_a),
    .alu_tag_b  (alu_tag_b),
    .alu_val_a  (alu_val_a),
    .alu_val_b  (alu_val_b)
  );

  div_rs #(
    .RS_SIZE (RS_SIZE)
  ) i_rs (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .div_start  (div_start),
    .div_rd     (div_rd),
    .div_op     (div_op),
    .div_src1   (div_src1),
    .div_src2   (div_src2),
    .div_rdy    (div_rdy),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .div_busy   (div_busy),
    .issue      (issue),
    .issue_rd   (issue_rd),
    .issue_op   (issue_op),
    .issue_src1 (issue_src1),
    .issue_src2 (issue_src2),
    .rs_full    (rs_full)
  );

  div_unit i_div (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .issue         (issue),
    .issue_rd      (issue_rd),
    .issue_op      (issue_op),
    .rd_val_a      (rd_val_a),
    .rd_val_b      (rd_val_b),
    .div_busy      (div_busy),
    .div_req       (div_req),
    .div_res_tag   (div_res_tag),
    .div_res_value (div_res_value),
    .div_grant     (div_grant)
  );

  alu_unit i_alu (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .alu_start     (alu_start),
    .alu_rd        (alu_rd),
    .alu_op        (alu_op),
    .alu_src1      (alu_src1),
    .alu_src2      (alu_src2),
    .alu_tag_a     (alu_tag_a),
    .alu_tag_b     (alu_tag_b),
    .alu_val_a     (alu_val_a),
    .alu_val_b     (alu_val_b),
    .alu_busy      (alu_busy),
    .alu_req       (alu_req),
    .alu_res_tag   (alu_res_tag),
    .alu_res_value (alu_res_value),
    .alu_grant     (alu_grant)
  );

  cdb_arbiter i_arb (
    .alu_req       (alu_req),
    .alu_res_tag   (alu_res_tag),
    .alu_res_value (alu_res_value),
    .div_req       (div_req),
    .div_res_tag   (div_res_tag),
    .div_res_value (div_res_value),
    .alu_grant     (alu_grant),
    .div_grant     (div_grant),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .cdb_value     (cdb_value)
  );

endmodule

`default_nettype wire

// ==== src/div_rs.sv ====
`default_nettype none

module div_rs #(
  parameter int RS_SIZE = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush,
  input  logic             div_start,
  input  ooo_pkg::tag_t    div_rd,
  input  ooo_pkg::div_op_t div_op,
  input  ooo_pkg::tag_t    div_src1,
  input  ooo_pkg::tag_t    div_src2,
  input  logic [1:0]       div_rdy,
  input  logic             cdb_valid,
  input  ooo_pkg::tag_t    cdb_tag,
  input  logic             div_busy,
  output logic             issue,
  output ooo_pkg::tag_t    issue_rd,
  output ooo_pkg::div_op_t issue_op,
  output ooo_pkg::tag_t    issue_src1,
  output ooo_pkg::tag_t    issue_src2,
  output logic             rs_full
);

  localparam int IDX_BITS = $clog2(RS_SIZE);

  logic [RS_SIZE-1:0] valid;
  logic [RS_SIZE-1:0] valid_next;
  logic [RS_SIZE-1:0] rdy1;
  logic [RS_SIZE-1:0] rdy2;

  ooo_pkg::tag_t    rd_q   [RS_SIZE];
  ooo_pkg::div_op_t op_q   [RS_SIZE];
  ooo_pkg::tag_t    src1_q [RS_SIZE];
  ooo_pkg::tag_t    src2_q [RS_SIZE];

  logic [IDX_BITS-1:0] free_idx;
  logic [IDX_BITS-1:0] issue_idx;
  logic                any_ready;
  logic                alloc;
  logic                cap1;
  logic                cap2;

  assign alloc = div_start && !rs_full;

  // a tag broadcast in the dispatch cycle counts as already produced.
  assign cap1 = div_rdy[0] || (cdb_valid && (cdb_tag == div_src1));
  assign cap2 = div_rdy[1] || (cdb_valid && (cdb_tag == div_src2));

  // scan downward so that the lowest matching index is kept.
  always_comb begin
    free_idx  = '0;
    issue_idx = '0;
    any_ready = 1'b0;
    for (int i = RS_SIZE - 1; i >= 0; i--) begin
      if (!valid[i]) free_idx = IDX_BITS'(i);
      if (valid[i] && rdy1[i] && rdy2[i]) begin
        issue_idx = IDX_BITS'(i);
        any_ready = 1'b1;
      end
    end
  end

  assign issue      = any_ready && !div_busy;
  assign issue_rd   = rd_q[issue_idx];
  assign issue_op   = op_q[issue_idx];
  assign issue_src1 = src1_q[issue_idx];
  assign issue_src2 = src2_q[issue_idx];

  always_comb begin
    valid_next = valid;
    if (issue) valid_next[issue_idx] = 1'b0; // the issued entry is freed at once.
    if (alloc) valid_next[free_idx] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      valid   <= '0;
      rs_full <= 1'b0;
    end else begin
      valid   <= valid_next;
      rs_full <= &valid_next;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_SIZE; i++) begin
      if (cdb_valid && (src1_q[i] == cdb_tag)) rdy1[i] <= 1'b1;
      if (cdb_valid && (src2_q[i] == cdb_tag)) rdy2[i] <= 1'b1;
    end
    if (alloc) begin
      rd_q[free_idx]   <= div_rd;
      op_q[free_idx]   <= div_op;
      src1_q[free_idx] <= div_src1;
      src2_q[free_idx] <= div_src2;
      rdy1[free_idx]   <= cap1;
      rdy2[free_idx]   <= cap2;
    end
  end

endmodule

`default_nettype wire

// ==== src/div_unit.sv ====
`default_nettype none

module div_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush,
  input  logic             issue,
  input  ooo_pkg::tag_t    issue_rd,
  input  ooo_pkg::div_op_t issue_op,
  input  ooo_pkg::data_t   rd_val_a,
  input  ooo_pkg::data_t   rd_val_b,
  output logic             div_busy,
  output logic             div_req,
  output ooo_pkg::tag_t    div_res_tag,
  output ooo_pkg::data_t   div_res_value,
  input  logic             div_grant
);

  localparam int W        = ooo_pkg::DATA_BITS;
  localparam int CNT_BITS = $clog2(W);

  ooo_pkg::div_state_t state;
  logic [CNT_BITS-1:0] count;
  ooo_pkg::data_t      quo_q;
  ooo_pkg::data_t      rem_q;
  ooo_pkg::data_t      dvsr_q;
  ooo_pkg::div_op_t    op_q;
  ooo_pkg::tag_t       rd_q;
  logic [W:0]          rem_shift;
  logic [W:0]          rem_next;
  logic                rem_ge;

  // one restoring step; a zero divisor always subtracts and so yields all ones.
  always_comb begin
    rem_shift = {rem_q, quo_q[W-1]};
    rem_ge    = rem_shift >= {1'b0, dvsr_q};
    rem_next  = rem_ge ? (rem_shift - {1'b0, dvsr_q}) : rem_shift;
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      state <= ooo_pkg::idle;
    end else begin
      case (state)
        ooo_pkg::idle: if (issue) state <= ooo_pkg::busy;
        ooo_pkg::busy: if (count == CNT_BITS'(W - 1)) state <= ooo_pkg::done;
        ooo_pkg::done: if (div_grant) state <= ooo_pkg::idle;
        default:       state <= ooo_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ooo_pkg::idle) && issue) begin
      quo_q  <= rd_val_a; // dividend shifts out as quotient bits shift in.
      rem_q  <= '0;
      dvsr_q <= rd_val_b;
      op_q   <= issue_op;
      rd_q   <= issue_rd;
      count  <= '0;
    end else if (state == ooo_pkg::busy) begin
      quo_q <= {quo_q[W-2:0], rem_ge};
      rem_q <= rem_next[W-1:0];
      count <= count + 1'b1;
    end
  end

  assign div_busy      = (state != ooo_pkg::idle);
  assign div_req       = (state == ooo_pkg::done);
  assign div_res_tag   = rd_q;
  assign div_res_value = op_q ? rem_q : quo_q;

endmodule

`default_nettype wire

// ==== src/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

  // one tag per physical register, 64 registers.
  typedef logic [5:0] tag_t;

  typedef logic [15:0] data_t;

  // 0 returns the quotient, 1 the remainder.
  typedef logic div_op_t;

  // 0 adds, 1 subtracts.
  typedef logic alu_op_t;

  typedef enum logic [1:0] {
    idle,
    busy,
    done
  } div_state_t;

  localparam int DATA_BITS = 16; // one quotient bit per step.

endpackage

`default_nettype wire

// ==== src/phys_regfile.sv ====
`default_nettype none

module phys_regfile (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           load_en,
  input  ooo_pkg::tag_t  load_tag,
  input  ooo_pkg::data_t load_value,
  input  logic           cdb_valid,
  input  ooo_pkg::tag_t  cdb_tag,
  input  ooo_pkg::data_t cdb_value,
  input  ooo_pkg::tag_t  rd_tag_a,
  input  ooo_pkg::tag_t  rd_tag_b,
  output ooo_pkg::data_t rd_val_a,
  output ooo_pkg::data_t rd_val_b,
  input  ooo_pkg::tag_t  alu_tag_a,
  input  ooo_pkg::tag_t  alu_tag_b,
  output ooo_pkg::data_t alu_val_a,
  output ooo_pkg::data_t alu_val_b
);

  localparam int NUM_REGS = 2 ** $bits(ooo_pkg::tag_t);

  ooo_pkg::data_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (load_en) regs[load_tag] <= load_value;
      if (cdb_valid) regs[cdb_tag] <= cdb_value; // the later write wins on a collision.
    end
  end

  assign rd_val_a  = regs[rd_tag_a];
  assign rd_val_b  = regs[rd_tag_b];
  assign alu_val_a = regs[alu_tag_a];
  assign alu_val_b = regs[alu_tag_b];

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period.
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1; // released in the same slot as the other inputs.
  end

endmodule

`default_nettype wire

// ==== test/tb_div_cluster.sv ====
`default_nettype none

module tb_div_cluster;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RS_SIZE = 8;
  localparam int N_LOAD  = 16;
  localparam int N_ALU   = 8;
  localparam int N_DIV   = 8;
  localparam int N_ZERO  = 4;
  localparam int N_CHAIN = 12;
  localparam int N_FLUSH = 3; // two wakeup ops and the quiet window.
  localparam int N_OPS   = N_LOAD + N_ALU + N_DIV + N_ZERO + N_CHAIN + RS_SIZE + N_FLUSH;
  localparam int CYCLE_LIMIT = 40 * N_OPS;

  localparam ooo_pkg::tag_t ZERO_TAG = 6'd15; // always holds zero.
  localparam ooo_pkg::tag_t DEAD_A   = 6'd62;
  localparam ooo_pkg::tag_t DEAD_B   = 6'd63;

  logic             clk;
  logic             rst_n;
  logic             flush;
  logic             load_en;
  ooo_pkg::tag_t    load_tag;
  ooo_pkg::data_t   load_value;
  logic             div_start;
  ooo_pkg::tag_t    div_rd;
  ooo_pkg::div_op_t div_op;
  ooo_pkg::tag_t    div_src1;
  ooo_pkg::tag_t    div_src2;
  logic [1:0]       div_rdy;
  logic             alu_start;
  ooo_pkg::tag_t    alu_rd;
  ooo_pkg::alu_op_t alu_op;
  ooo_pkg::tag_t    alu_src1;
  ooo_pkg::tag_t    alu_src2;
  logic             rs_full;
  logic             alu_busy;
  logic             div_busy;
  logic             cdb_valid;
  ooo_pkg::tag_t    cdb_tag;
  ooo_pkg::data_t   cdb_value;

  ooo_pkg::data_t model_val [64];
  logic           pending [64];
  int             pending_count = 0;
  int             errors = 0;
  int             checks = 0;
  int             tests = 0;
  int             cycles = 0;
  logic [31:0]    lcg_state = 32'd28;

  tb_clock i_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  div_cluster #(
    .RS_SIZE (RS_SIZE)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .load_en    (load_en),
    .load_tag   (load_tag),
    .load_value (load_value),
    .div_start  (div_start),
    .div_rd     (div_rd),
    .div_op     (div_op),
    .div_src1   (div_src1),
    .div_src2   (div_src2),
    .div_rdy    (div_rdy),
    .alu_start  (alu_start),
    .alu_rd     (alu_rd),
    .alu_op     (alu_op),
    .alu_src1   (alu_src1),
    .alu_src2   (alu_src2),
    .rs_full    (rs_full),
    .alu_busy   (alu_busy),
    .div_busy   (div_busy),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .cdb_value  (cdb_value)
  );

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  // subtraction adds the two's complement, and the sum is taken modulo 2**16.
  function automatic ooo_pkg::data_t alu_model(input ooo_pkg::alu_op_t op,
                                               input ooo_pkg::data_t a,
                                               input ooo_pkg::data_t b);
    int wide;
    wide = int'(a) + (op ? (65536 - int'(b)) : int'(b));
    return ooo_pkg::data_t'(wide % 65536);
  endfunction

  // a zero divisor gives all ones, or the dividend as remainder.
  function automatic ooo_pkg::data_t div_model(input ooo_pkg::div_op_t op,
                                               input ooo_pkg::data_t a,
                                               input ooo_pkg::data_t b);
    if (b == '0) return op ? a : 16'hffff;
    return op ? (a % b) : (a / b);
  endfunction

  task automatic check_equal(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_reg(input ooo_pkg::tag_t tag, input ooo_pkg::data_t value);
    load_en    = 1'b1;
    load_tag   = tag;
    load_value = value;
    model_val[tag] = value;
    step_cycle();
    load_en = 1'b0;
  endtask

  task automatic send_alu(input ooo_pkg::tag_t rd, input ooo_pkg::alu_op_t op,
                          input ooo_pkg::tag_t src1, input ooo_pkg::tag_t src2);
    while (alu_busy) step_cycle();
    alu_start = 1'b1;
    alu_rd    = rd;
    alu_op    = op;
    alu_src1  = src1;
    alu_src2  = src2;
    model_val[rd] = alu_model(op, model_val[src1], model_val[src2]);
    pending[rd] = 1'b1;
    pending_count++;
    step_cycle();
    alu_start = 1'b0;
    check_equal("alu_busy", {15'd0, alu_busy}, 16'h0001);
  endtask

  // a source counts as ready once its tag has left the pending set.
  task automatic send_div(input ooo_pkg::tag_t rd, input ooo_pkg::div_op_t op,
                          input ooo_pkg::tag_t src1, input ooo_pkg::tag_t src2,
                          input logic [1:0] rdy_mask, input logic track);
    while (rs_full) step_cycle();
    div_start = 1'b1;
    div_rd    = rd;
    div_op    = op;
    div_src1  = src1;
    div_src2  = src2;
    div_rdy   = rdy_mask & {!pending[src2], !pending[src1]};
    if (track) begin
      model_val[rd] = div_model(op, model_val[src1], model_val[src2]);
      pending[rd] = 1'b1;
      pending_count++;
    end
    step_cycle();
    div_start = 1'b0;
  endtask

  task automatic wait_drain();
    while (pending_count != 0) step_cycle();
  endtask

  task automatic report_test(input string name, input int err_start);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_start) ? "passed" : "failed");
  endtask

  // every broadcast must match exactly one pending tag.
  always @(negedge clk) begin
    if (rst_n && cdb_valid) begin
      if (!pending[cdb_tag]) begin
        errors++;
        $display("broadcast of tag %0d that has no pending operation at %0t",
                 cdb_tag, $time);
      end else begin
        check_equal("cdb_value", cdb_value, model_val[cdb_tag]);
        pending[cdb_tag] = 1'b0;
        pending_count--;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    logic [15:0]   r;
    ooo_pkg::tag_t s1;
    ooo_pkg::tag_t s2;
    int            err_start;
    flush      = 1'b0;
    load_en    = 1'b0;
    load_tag   = '0;
    load_value = '0;
    div_start  = 1'b0;
    div_rd     = '0;
    div_op     = 1'b0;
    div_src1   = '0;
    div_src2   = '0;
    div_rdy    = 2'b00;
    alu_start  = 1'b0;
    alu_rd     = '0;
    alu_op     = 1'b0;
    alu_src1   = '0;
    alu_src2   = '0;
    for (int t = 0; t < 64; t++) begin
      pending[t]   = 1'b0;
      model_val[t] = '0;
    end
    @(posedge rst_n);

    // tags 8 to 14 hold small values so that quotients are not mostly zero.
    for (int i = 0; i < N_LOAD - 1; i++) begin
      r = next_rand();
      load_reg(ooo_pkg::tag_t'(i), (i < 8) ? r : {8'd0, r[7:0]});
    end
    load_reg(ZERO_TAG, 16'h0000);

    err_start = errors;
    for (int i = 0; i < N_ALU; i++) begin
      s1 = ooo_pkg::tag_t'(next_rand() % 16'd15);
      s2 = ooo_pkg::tag_t'(next_rand() % 16'd15);
      r = next_rand();
      send_alu(ooo_pkg::tag_t'(16 + i), r[0], s1, s2);
    end
    wait_drain();
    report_test("alu add/sub", err_start);

    err_start = errors;
    for (int i = 0; i < N_DIV; i++) begin
      s1 = ooo_pkg::tag_t'(next_rand() % 16'd8);
      s2 = ooo_pkg::tag_t'(8 + (next_rand() % 16'd7));
      r = next_rand();
      send_div(ooo_pkg::tag_t'(24 + i), r[0], s1, s2, 2'b11, 1'b1);
    end
    wait_drain();
    report_test("divide and remainder", err_start);

    err_start = errors;
    for (int i = 0; i < N_ZERO; i++) begin
      s1 = ooo_pkg::tag_t'(next_rand() % 16'd15);
      send_div(ooo_pkg::tag_t'(48 + i), ooo_pkg::div_op_t'(i % 2), s1, ZERO_TAG, 2'b11, 1'b1);
    end
    wait_drain();
    report_test("zero divisor", err_start);

    // divide sources may be earlier results of this test still in flight.
    err_start = errors;
    for (int i = 0; i < N_CHAIN; i++) begin
      r = next_rand();
      if (r[0]) begin
        s1 = ooo_pkg::tag_t'(next_rand() % 16'd15);
        s2 = ooo_pkg::tag_t'(next_rand() % 16'd15);
        send_alu(ooo_pkg::tag_t'(32 + i), r[1], s1, s2);
      end else begin
        r = next_rand();
        s1 = (i > 0 && r[0]) ? ooo_pkg::tag_t'(32 + ((r >> 1) % 16'(i)))
                             : ooo_pkg::tag_t'(r % 16'd15);
        r = next_rand();
        s2 = (i > 0 && r[0]) ? ooo_pkg::tag_t'(32 + ((r >> 1) % 16'(i)))
                             : ooo_pkg::tag_t'(8 + (r % 16'd7));
        send_div(ooo_pkg::tag_t'(32 + i), r[1], s1, s2, 2'b11, 1'b1);
      end
    end
    wait_drain();
    report_test("chained dependencies", err_start);

    err_start = errors;
    for (int i = 0; i < RS_SIZE; i++) begin
      send_div(ooo_pkg::tag_t'(16 + i), 1'b0, DEAD_A, DEAD_B, 2'b00, 1'b0);
    end
    check_equal("rs_full", {15'd0, rs_full}, 16'h0001);
    report_test("station full", err_start);

    // broadcasting the waited-on tags would wake any entry that survived.
    err_start = errors;
    flush = 1'b1;
    step_cycle();
    flush = 1'b0;
    check_equal("rs_full", {15'd0, rs_full}, 16'h0000);
    send_alu(DEAD_A, 1'b0, 6'd1, 6'd2);
    send_alu(DEAD_B, 1'b1, 6'd3, 6'd4);
    repeat (40) step_cycle();
    wait_drain();
    check_equal("div_busy", {15'd0, div_busy}, 16'h0000);
    report_test("flush", err_start);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
